/* compile.f */
verilog/thread_ctrl_pkg.sv
verilog/inst_issue.sv
verilog/subcore_slot.sv
verilog/living_monitor.sv
verilog/thread_ctrl_top.sv
testbench/thread_ctrl_assert.sv
testbench/tb_thread_ctrl.sv

/* testbench/tb_thread_ctrl.sv */
`timescale 1ns/1ps

module tb_thread_ctrl;
    import thread_ctrl_pkg::*;

    // instruction, byte to supply, expected value, core to end, expected count
    typedef struct packed {
        inst_word_u           inst;
        logic [7:0]           in_byte;
        logic [31:0]          exp_val;
        logic [core_id_w-1:0] end_core;
        logic [core_id_w:0]   count;
    } entry_t;

    logic                             clk           = 1'b0;
    logic                             rstn          = 1'b0;
    logic                             inst_valid    = 1'b0;
    logic                             inst_ready;
    inst_word_u                       inst          = '0;
    logic                             in_valid      = 1'b0;
    logic                             in_ready;
    logic [7:0]                       in_data       = 8'h00;
    logic                             out_valid;
    logic                             out_ready     = 1'b0;
    logic [7:0]                       out_data;
    logic                             rd_valid;
    logic [reg_id_w-1:0]              rd_rt;
    logic [31:0]                      rd_data;
    logic [subcore_num-1:0]           exec_requested;
    logic [subcore_num-1:0][pc_w-1:0] requested_pc;
    logic [subcore_num-1:0]           subcore_ended = '0;
    logic [core_id_w:0]               living_count;

    entry_t      tests [12];
    logic [31:0] rng = 32'd42950;
    int          errors = 0;
    int          err_before;

    thread_ctrl_top thread_ctrl_top_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic int total_errors();
        return errors + thread_ctrl_top_i.thread_ctrl_assert_i.fail_count;
    endfunction

    // ====================
    // compare tasks
    // ====================

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_pc(input logic [pc_w-1:0] got, input logic [pc_w-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input logic [core_id_w:0] got, input logic [core_id_w:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input int n, input string what);
        if (n > 64) begin
            $display("timeout while waiting for %s", what);
            $display("Test failed");
            $finish;
        end
    endtask

    // ====================
    // one table entry
    // ====================

    task automatic run_test(input entry_t e);
        int n;
        int hs;
        @(posedge clk);
        #1;
        inst_valid = 1'b1;
        inst       = e.inst;
        for (n = 0; !inst_ready; n++) begin
            stop_on_timeout(n, "inst_ready");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        inst_valid = 1'b0;
        case (e.inst.thread.opcode)
            op_fork: begin
                for (n = 0; exec_requested == '0; n++) begin
                    stop_on_timeout(n, "exec_requested");
                    @(negedge clk);
                end
                check_word(32'(exec_requested), 32'd1 << e.inst.thread.core_id, "exec_requested");
                check_pc(requested_pc[e.inst.thread.core_id], e.exp_val, "requested_pc");
                check_count(living_count, e.count, "living_count after fork");
                @(negedge clk);
                check_word(32'(exec_requested), 32'd0, "exec_requested after the pulse");
            end
            op_join: begin
                // random run time of the subcore
                rng = xorshift(rng);
                repeat (rng % 4 + 1) begin
                    @(negedge clk);
                    check_word(32'(inst_ready), 32'd0, "inst_ready while joining");
                end
                @(posedge clk);
                #1;
                subcore_ended[e.end_core] = 1'b1;
                @(posedge clk);
                #1;
                subcore_ended = '0;
                for (n = 0; !inst_ready; n++) begin
                    stop_on_timeout(n, "inst_ready after the join");
                    @(negedge clk);
                end
                check_count(living_count, e.count, "living_count after join");
            end
            op_inll, op_inlh, op_inul, op_inuh: begin
                in_valid = 1'b1;
                in_data  = e.in_byte;
                for (n = 0; !in_ready; n++) begin
                    stop_on_timeout(n, "in_ready");
                    @(negedge clk);
                end
                @(posedge clk);
                #1;
                in_valid = 1'b0;
                for (n = 0; !rd_valid; n++) begin
                    stop_on_timeout(n, "rd_valid");
                    @(negedge clk);
                end
                check_word(rd_data, e.exp_val, "rd_data");
                check_word(32'(rd_rt), 32'(e.inst.io.rt), "rd_rt");
                check_word(32'(in_ready), 32'd0, "in_ready after the byte");
            end
            op_outll: begin
                hs = 0;
                for (n = 0; hs == 0; n++) begin
                    stop_on_timeout(n, "the out handshake");
                    rng       = xorshift(rng);
                    out_ready = rng[0];
                    @(negedge clk);
                    check_word(32'(inst_ready), 32'd0, "inst_ready before the out handshake");
                    if (out_valid && out_ready) begin
                        check_byte(out_data, e.exp_val[7:0], "out_data");
                        hs++;
                    end
                    @(posedge clk);
                    #1;
                end
                out_ready = 1'b0;
                check_word(32'(out_valid), 32'd0, "out_valid after the handshake");
                check_word(32'(inst_ready), 32'd1, "inst_ready after the handshake");
            end
            default: begin
                check_word(32'({inst_ready, out_valid, rd_valid}), 32'b100, "ready and valids");
                check_count(living_count, e.count, "living_count after other opcode");
            end
        endcase
    endtask

    initial begin
        tests[0]  = '{{op_fork, 4'd0, 32'h0000_1000, 22'd0}, 8'h00, 32'h0000_1000, 4'd0, 5'd1};
        tests[1]  = '{{op_fork, 4'd2, 32'h2468_ace0, 22'd0}, 8'h00, 32'h2468_ace0, 4'd0, 5'd2};
        tests[2]  = '{{op_inll, 5'd5, 8'h00, 45'd0}, 8'ha5, 32'h0000_00a5, 4'd0, 5'd2};
        tests[3]  = '{{op_fork, 4'd3, 32'h0000_3f00, 22'd0}, 8'h00, 32'h0000_3f00, 4'd0, 5'd3};
        tests[4]  = '{{op_join, 4'd2, 32'h0000_0000, 22'd0}, 8'h00, 32'h0000_0000, 4'd2, 5'd2};
        tests[5]  = '{{op_inlh, 5'd9, 8'h00, 45'd0}, 8'h3c, 32'h0000_3c00, 4'd0, 5'd2};
        tests[6]  = '{{op_outll, 5'd0, 8'h96, 45'd0}, 8'h00, 32'h0000_0096, 4'd0, 5'd2};
        tests[7]  = '{{op_inul, 5'd17, 8'h00, 45'd0}, 8'h7e, 32'h007e_0000, 4'd0, 5'd2};
        tests[8]  = '{{6'h05, 58'd0}, 8'h00, 32'h0000_0000, 4'd0, 5'd2};
        tests[9]  = '{{op_inuh, 5'd31, 8'h00, 45'd0}, 8'hc1, 32'hc100_0000, 4'd0, 5'd2};
        tests[10] = '{{op_outll, 5'd0, 8'h4b, 45'd0}, 8'h00, 32'h0000_004b, 4'd0, 5'd2};
        tests[11] = '{{op_join, 4'd0, 32'h0000_0000, 22'd0}, 8'h00, 32'h0000_0000, 4'd0, 5'd1};
        repeat (3) @(posedge clk);
        #1;
        rstn = 1'b1;
        check_word(32'(inst_ready), 32'd1, "inst_ready after reset");
        check_word(32'(exec_requested), 32'd0, "exec_requested after reset");
        check_word(32'({in_ready, out_valid, rd_valid}), 32'd0, "stream flags after reset");
        check_count(living_count, '0, "living_count after reset");
        $display("test reset: %s", (total_errors() == 0) ? "ok" : "failed");
        for (int i = 0; i < 12; i++) begin
            err_before = total_errors();
            run_test(tests[i]);
            $display("test %0d, opcode %h: %s", i, tests[i].inst.thread.opcode,
                     (total_errors() == err_before) ? "ok" : "failed");
        end
        $display("13 tests run, %0d errors", total_errors());
        if (total_errors() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* testbench/thread_ctrl_assert.sv */
`timescale 1ns/1ps

module thread_ctrl_assert (
    input logic                                    clk,
    input logic                                    rstn,
    input logic                                    inst_valid,
    input logic                                    inst_ready,
    input thread_ctrl_pkg::inst_word_u             inst,
    input logic                                    in_valid,
    input logic                                    in_ready,
    input logic                                    out_valid,
    input logic                                    out_ready,
    input logic [7:0]                              out_data,
    input logic                                    rd_valid,
    input logic [thread_ctrl_pkg::subcore_num-1:0] exec_requested
);

    // number of failed assertions so far
    int fail_count = 0;

    // ====================
    // stream stability
    // ====================

    inst_hold: assert property (@(posedge clk) disable iff (!rstn)
        inst_valid && !inst_ready |=> inst_valid && $stable(inst))
        else begin
            $error("instruction changed or withdrawn before it was taken");
            fail_count++;
        end

    in_hold: assert property (@(posedge clk) disable iff (!rstn)
        in_valid && !in_ready |=> in_valid)
        else begin
            $error("input byte withdrawn before it was taken");
            fail_count++;
        end

    out_hold: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            $error("output byte changed or withdrawn under back-pressure");
            fail_count++;
        end

    // ====================
    // pulses
    // ====================

    rd_pulse: assert property (@(posedge clk) disable iff (!rstn)
        rd_valid |=> !rd_valid)
        else begin
            $error("rd_valid longer than one cycle");
            fail_count++;
        end

    // no bit may stay high two cycles in a row
    exec_pulse: assert property (@(posedge clk) disable iff (!rstn)
        |exec_requested |=> (exec_requested & $past(exec_requested)) == '0)
        else begin
            $error("exec_requested longer than one cycle");
            fail_count++;
        end

endmodule

bind thread_ctrl_top thread_ctrl_assert thread_ctrl_assert_i (.*);

/* verilog/inst_issue.sv */
`timescale 1ns/1ps

module inst_issue (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  logic                                    inst_valid,
    output logic                                    inst_ready,
    input  thread_ctrl_pkg::inst_word_u             inst,
    input  logic                                    in_valid,
    output logic                                    in_ready,
    input  logic [7:0]                              in_data,
    output logic                                    out_valid,
    input  logic                                    out_ready,
    output logic [7:0]                              out_data,
    output logic                                    rd_valid,
    output logic [thread_ctrl_pkg::reg_id_w-1:0]    rd_rt,
    output logic [31:0]                             rd_data,
    output logic [thread_ctrl_pkg::subcore_num-1:0] fork_start,
    output logic [thread_ctrl_pkg::pc_w-1:0]        fork_pc,
    output logic                                    join_pending,
    output logic [thread_ctrl_pkg::core_id_w-1:0]   join_target,
    input  logic                                    join_done
);
    import thread_ctrl_pkg::*;

    // fsm state, run when no flag is set
    logic       joining;
    logic       reading;
    logic       writing;

    logic       take;
    opcode_t    opcode;
    logic       is_fork;
    logic       is_join;
    logic       is_in;
    logic       is_out;
    logic [1:0] lane_sel;
    logic [1:0] in_lane;

    assign inst_ready   = ~(joining | reading | writing);
    assign take         = inst_valid & inst_ready;
    assign join_pending = joining;
    assign in_ready     = reading;
    assign out_valid    = writing;

    // ====================
    // decode
    // ====================

    assign opcode  = inst.thread.opcode;
    assign is_fork = (opcode == op_fork);
    assign is_join = (opcode == op_join);
    assign is_out  = (opcode == op_outll);

    always_comb begin
        is_in    = 1'b1;
        lane_sel = 2'd0;
        case (opcode)
            op_inll: lane_sel = 2'd0;
            op_inlh: lane_sel = 2'd1;
            op_inul: lane_sel = 2'd2;
            op_inuh: lane_sel = 2'd3;
            default: is_in = 1'b0;
        endcase
    end

    // ====================
    // sequencing
    // ====================

    always_ff @(posedge clk) begin
        if (!rstn) begin
            joining    <= 1'b0;
            reading    <= 1'b0;
            writing    <= 1'b0;
            fork_start <= '0;
            rd_valid   <= 1'b0;
        end else begin
            // one cycle fork pulse to the addressed slot
            for (int i = 0; i < subcore_num; i++) begin
                fork_start[i] <= take && is_fork && (inst.thread.core_id == core_id_w'(i));
            end
            rd_valid <= reading && in_valid;

            if (take && is_join) begin
                joining <= 1'b1;
            end else if (joining && join_done) begin
                joining <= 1'b0;
            end

            if (take && is_in) begin
                reading <= 1'b1;
            end else if (reading && in_valid) begin
                reading <= 1'b0;
            end

            if (take && is_out) begin
                writing <= 1'b1;
            end else if (writing && out_ready) begin
                writing <= 1'b0;
            end
        end
    end

    // operands, loaded per instruction kind
    always_ff @(posedge clk) begin
        if (take && is_fork) begin
            fork_pc <= inst.thread.pc;
        end
        if (take && is_join) begin
            join_target <= inst.thread.core_id;
        end
        if (take && is_in) begin
            rd_rt   <= inst.io.rt;
            in_lane <= lane_sel;
        end
        if (take && is_out) begin
            out_data <= inst.io.data;
        end
        // byte into its lane, zeros elsewhere
        if (reading && in_valid) begin
            rd_data <= 32'(in_data) << {in_lane, 3'b000};
        end
    end

endmodule

/* verilog/living_monitor.sv */
`timescale 1ns/1ps

module living_monitor (
    input  logic [thread_ctrl_pkg::subcore_num-1:0] slot_live,
    input  logic [thread_ctrl_pkg::subcore_num-1:0] slot_done,
    input  logic                                    join_pending,
    input  logic [thread_ctrl_pkg::core_id_w-1:0]   join_target,
    output logic [thread_ctrl_pkg::core_id_w:0]     living_count,
    output logic                                    join_done,
    output logic [thread_ctrl_pkg::subcore_num-1:0] join_release
);
    import thread_ctrl_pkg::*;

    // population count of live slots
    always_comb begin
        living_count = '0;
        for (int i = 0; i < subcore_num; i++) begin
            living_count = living_count + (core_id_w + 1)'(slot_live[i]);
        end
    end

    // done flag of the join target
    always_comb begin
        join_done = 1'b0;
        for (int i = 0; i < subcore_num; i++) begin
            if (join_target == core_id_w'(i)) begin
                join_done = slot_done[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < subcore_num; i++) begin
            join_release[i] = join_pending && join_done && (join_target == core_id_w'(i));
        end
    end

endmodule

/* verilog/subcore_slot.sv */
`timescale 1ns/1ps

module subcore_slot (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             fork_start,
    input  logic [thread_ctrl_pkg::pc_w-1:0] fork_pc,
    input  logic                             subcore_ended,
    input  logic                             join_release,
    output logic                             exec_requested,
    output logic [thread_ctrl_pkg::pc_w-1:0] requested_pc,
    output logic                             slot_live,
    output logic                             slot_done
);

    // ====================
    // life cycle
    // ====================

    // idle: !live, running: live & !done, ended: live & done
    always_ff @(posedge clk) begin
        if (!rstn) begin
            exec_requested <= 1'b0;
            slot_live      <= 1'b0;
            slot_done      <= 1'b0;
        end else begin
            exec_requested <= fork_start;
            if (fork_start) begin
                // a fork to a live slot restarts it
                slot_live <= 1'b1;
                slot_done <= 1'b0;
            end else if (join_release) begin
                slot_live <= 1'b0;
                slot_done <= 1'b0;
            end else if (subcore_ended && slot_live) begin
                slot_done <= 1'b1;
            end
        end
    end

    // start pc for the subcore
    always_ff @(posedge clk) begin
        if (fork_start) begin
            requested_pc <= fork_pc;
        end
    end

endmodule

/* verilog/thread_ctrl_pkg.sv */
package thread_ctrl_pkg;

    // ====================
    // sizes
    // ====================

    // 2 to 16 slots are supported
    localparam int subcore_num = 4;
    localparam int core_id_w   = 4;
    localparam int pc_w        = 32;
    localparam int inst_w      = 64;
    localparam int opcode_w    = 6;
    localparam int reg_id_w    = 5;

    typedef logic [opcode_w-1:0] opcode_t;

    // ====================
    // opcodes
    // ====================

    localparam opcode_t op_fork  = 6'h30;
    localparam opcode_t op_join  = 6'h31;
    // byte in, lanes 0..3
    localparam opcode_t op_inll  = 6'h38;
    localparam opcode_t op_inlh  = 6'h39;
    localparam opcode_t op_inul  = 6'h3a;
    localparam opcode_t op_inuh  = 6'h3b;
    localparam opcode_t op_outll = 6'h3c;

    // opcode always in the top bits, the rest depends on the kind
    typedef union packed {
        struct packed {
            opcode_t                                   opcode;
            logic [core_id_w-1:0]                      core_id;
            logic [pc_w-1:0]                           pc;
            logic [inst_w-opcode_w-core_id_w-pc_w-1:0] pad;
        } thread;
        struct packed {
            opcode_t                                   opcode;
            logic [reg_id_w-1:0]                       rt;
            logic [7:0]                                data;
            logic [inst_w-opcode_w-reg_id_w-8-1:0]     pad;
        } io;
    } inst_word_u;

endpackage

/* verilog/thread_ctrl_top.sv */
`timescale 1ns/1ps

module thread_ctrl_top (
    input  logic                                    clk,
    input  logic                                    rstn,
    input  logic                                    inst_valid,
    output logic                                    inst_ready,
    input  thread_ctrl_pkg::inst_word_u             inst,
    input  logic                                    in_valid,
    output logic                                    in_ready,
    input  logic [7:0]                              in_data,
    output logic                                    out_valid,
    input  logic                                    out_ready,
    output logic [7:0]                              out_data,
    output logic                                    rd_valid,
    output logic [thread_ctrl_pkg::reg_id_w-1:0]    rd_rt,
    output logic [31:0]                             rd_data,
    output logic [thread_ctrl_pkg::subcore_num-1:0] exec_requested,
    output logic [thread_ctrl_pkg::subcore_num-1:0][thread_ctrl_pkg::pc_w-1:0] requested_pc,
    input  logic [thread_ctrl_pkg::subcore_num-1:0] subcore_ended,
    output logic [thread_ctrl_pkg::core_id_w:0]     living_count
);
    import thread_ctrl_pkg::*;

    logic [subcore_num-1:0] fork_start;
    logic [pc_w-1:0]        fork_pc;
    logic [subcore_num-1:0] slot_live;
    logic [subcore_num-1:0] slot_done;
    logic                   join_pending;
    logic [core_id_w-1:0]   join_target;
    logic                   join_done;
    logic [subcore_num-1:0] join_release;

    // ====================
    // issue
    // ====================

    inst_issue inst_issue_i (
        .clk          (clk),
        .rstn         (rstn),
        .inst_valid   (inst_valid),
        .inst_ready   (inst_ready),
        .inst         (inst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_data      (in_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_data     (out_data),
        .rd_valid     (rd_valid),
        .rd_rt        (rd_rt),
        .rd_data      (rd_data),
        .fork_start   (fork_start),
        .fork_pc      (fork_pc),
        .join_pending (join_pending),
        .join_target  (join_target),
        .join_done    (join_done)
    );

    // ====================
    // slots
    // ====================

    for (genvar i = 0; i < subcore_num; i++) begin : g_slot
        subcore_slot subcore_slot_i (
            .clk            (clk),
            .rstn           (rstn),
            .fork_start     (fork_start[i]),
            .fork_pc        (fork_pc),
            .subcore_ended  (subcore_ended[i]),
            .join_release   (join_release[i]),
            .exec_requested (exec_requested[i]),
            .requested_pc   (requested_pc[i]),
            .slot_live      (slot_live[i]),
            .slot_done      (slot_done[i])
        );
    end

    living_monitor living_monitor_i (
        .slot_live    (slot_live),
        .slot_done    (slot_done),
        .join_pending (join_pending),
        .join_target  (join_target),
        .living_count (living_count),
        .join_done    (join_done),
        .join_release (join_release)
    );

endmodule
